// File: rtl/ucode_macros.svh
// sizes of the multiply unit; the ROM depth must hold both routines and stay a power of two.
`ifndef UCODE_MACROS_SVH
`define UCODE_MACROS_SVH

// one data word, also the width of every scratch register.
`define UC_DATA_W 16

// architectural registers in the file.
`define UC_NREGS 16

// micro-instruction store depth, both routines live here.
`define UC_ROM_DEPTH 32

// micro-instruction width.
// the layout is uop, dst, src, lit, arg, reserved, value.
`define UC_INSN_W 32

`endif

// File: rtl/ucode_pkg.sv
// shared types of the multiply unit; the signed opcodes are named here but not executed.
`default_nettype none
`include "ucode_macros.svh"

package ucode_pkg;

    // micro-op codes held in the top nibble of a micro-instruction.
    typedef enum logic [3:0] {
        uop_nop  = 4'd0,
        uop_mov  = 4'd1,
        uop_add  = 4'd2,
        uop_sub  = 4'd3,
        uop_cmp  = 4'd4,
        uop_bne  = 4'd5,
        uop_b    = 4'd6,
        uop_halt = 4'd7
    } uop_t;

    // macro opcodes as they arrive on the request port.
    typedef enum logic [6:0] {
        mul_imm  = 7'b0010000,
        muls_imm = 7'b0011000,
        mul_reg  = 7'b0110000,
        muls_reg = 7'b0111000
    } macro_op_t;

    typedef enum logic [1:0] {sc_acc, sc_cnt, sc_mcand} scratch_t; // scratch register select.

    // one micro-instruction; val is the literal or the signed branch offset.
    typedef struct packed {
        uop_t                     op;
        scratch_t                 dst;
        scratch_t                 src;
        logic                     lit;  // source is val.
        logic                     arg;  // source is the held multiplier.
        logic [`UC_INSN_W-27:0]   rsvd;
        logic [15:0]              val;
    } uinsn_t;

    localparam logic [$clog2(`UC_ROM_DEPTH)-1:0] rt_mul_imm = 0;  // routine entry points.
    localparam logic [$clog2(`UC_ROM_DEPTH)-1:0] rt_mul_reg = 16;

endpackage

`default_nettype wire

// File: rtl/macro_decode.sv
// request front end; reads operands through the file's registered ports and drops a req while busy.
`timescale 1ns/1ns
`default_nettype none
`include "ucode_macros.svh"

module macro_decode (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic                              req,
    input  wire logic [6:0]                        opcode,
    input  wire logic [$clog2(`UC_NREGS)-1:0]      dest_reg,
    input  wire logic [$clog2(`UC_NREGS)-1:0]      reg1,
    input  wire logic [$clog2(`UC_NREGS)-1:0]      reg2,
    input  wire logic [`UC_DATA_W-1:0]             immediate,
    output logic      [$clog2(`UC_NREGS)-1:0]      rd_addr_a,
    output logic      [$clog2(`UC_NREGS)-1:0]      rd_addr_b,
    input  wire logic [`UC_DATA_W-1:0]             rd_data_a,
    input  wire logic [`UC_DATA_W-1:0]             rd_data_b,
    input  wire logic                              seq_done,
    output logic                                   busy,
    output logic                                   illegal,
    output logic                                   start,
    output logic      [$clog2(`UC_ROM_DEPTH)-1:0]  start_addr,
    output logic      [`UC_DATA_W-1:0]             op_a,
    output logic      [`UC_DATA_W-1:0]             op_b,
    output logic      [$clog2(`UC_NREGS)-1:0]      wb_reg
);

    logic                               legal;     // opcode is one of the two mul forms.
    logic                               is_imm;
    logic                               accept;    // req taken this cycle.
    logic                               rd_pend;   // operand read in flight.
    logic                               imm_sel;
    logic [`UC_DATA_W-1:0]              imm_q;
    logic [$clog2(`UC_ROM_DEPTH)-1:0]   addr_sel;

    assign rd_addr_a = reg1;    // file registers the address itself.
    assign rd_addr_b = reg2;
    assign accept    = req && !busy;

    always_comb begin
        legal    = 1'b1;
        is_imm   = 1'b0;
        addr_sel = ucode_pkg::rt_mul_reg;
        case (ucode_pkg::macro_op_t'(opcode))
            ucode_pkg::mul_imm: begin
                is_imm   = 1'b1;
                addr_sel = ucode_pkg::rt_mul_imm;
            end
            ucode_pkg::mul_reg: is_imm = 1'b0;
            default:            legal  = 1'b0;  // signed forms land here too.
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            illegal <= 1'b0;
            rd_pend <= 1'b0;
            start   <= 1'b0;
        end else begin
            illegal <= accept && !legal;    // one pulse, busy stays low.
            rd_pend <= accept && legal;
            start   <= rd_pend;             // two cycles after req.
            if (accept && legal) begin
                busy <= 1'b1;
            end else if (seq_done) begin
                busy <= 1'b0;               // drops as done rises.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            imm_sel    <= is_imm;
            imm_q      <= immediate;
            start_addr <= addr_sel;
            wb_reg     <= dest_reg;
        end
        if (rd_pend) begin
            op_a <= rd_data_a;                          // multiplicand.
            op_b <= imm_sel ? imm_q : rd_data_b;        // multiplier.
        end
    end

endmodule

`default_nettype wire

// File: rtl/ucode_rom.sv
// microcode store with one registered read; both routines are 9 words and start at the pkg entry points.
`timescale 1ns/1ns
`default_nettype none
`include "ucode_macros.svh"

module ucode_rom (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic [$clog2(`UC_ROM_DEPTH)-1:0]  rom_addr,
    output logic      [`UC_INSN_W-1:0]             rom_insn
);

    localparam int aw = $clog2(`UC_ROM_DEPTH);

    // pack the fields of one micro-instruction.
    function automatic ucode_pkg::uinsn_t mk(
        input ucode_pkg::uop_t     op,
        input ucode_pkg::scratch_t dst,
        input ucode_pkg::scratch_t src,
        input logic                lit,
        input logic                arg,
        input logic [15:0]         val
    );
        mk.op   = op;
        mk.dst  = dst;
        mk.src  = src;
        mk.lit  = lit;
        mk.arg  = arg;
        mk.rsvd = '0;
        mk.val  = val;
    endfunction

    // word idx of the shift-free multiply loop, relative to the routine start.
    function automatic logic [`UC_INSN_W-1:0] routine_word(input logic [aw-1:0] idx);
        case (idx)
            0: routine_word = mk(ucode_pkg::uop_mov, ucode_pkg::sc_cnt, ucode_pkg::sc_acc,
                                 1'b0, 1'b1, 16'd0);            // cnt = multiplier.
            1: routine_word = mk(ucode_pkg::uop_mov, ucode_pkg::sc_acc, ucode_pkg::sc_acc,
                                 1'b1, 1'b0, 16'd0);            // acc = 0.
            2: routine_word = mk(ucode_pkg::uop_cmp, ucode_pkg::sc_cnt, ucode_pkg::sc_acc,
                                 1'b1, 1'b0, 16'd0);            // loop test.
            3: routine_word = mk(ucode_pkg::uop_bne, ucode_pkg::sc_acc, ucode_pkg::sc_acc,
                                 1'b0, 1'b0, 16'd2);            // into the body.
            4: routine_word = mk(ucode_pkg::uop_b, ucode_pkg::sc_acc, ucode_pkg::sc_acc,
                                 1'b0, 1'b0, 16'd4);            // out to halt.
            5: routine_word = mk(ucode_pkg::uop_add, ucode_pkg::sc_acc, ucode_pkg::sc_mcand,
                                 1'b0, 1'b0, 16'd0);
            6: routine_word = mk(ucode_pkg::uop_sub, ucode_pkg::sc_cnt, ucode_pkg::sc_acc,
                                 1'b1, 1'b0, 16'd1);
            7: routine_word = mk(ucode_pkg::uop_b, ucode_pkg::sc_acc, ucode_pkg::sc_acc,
                                 1'b0, 1'b0, 16'(-5));          // back to cmp.
            8: routine_word = mk(ucode_pkg::uop_halt, ucode_pkg::sc_acc, ucode_pkg::sc_acc,
                                 1'b0, 1'b0, 16'd0);
            default: routine_word = '0;                          // nop fill.
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            rom_insn <= '0;
        end else if (rom_addr >= ucode_pkg::rt_mul_reg) begin
            rom_insn <= routine_word(rom_addr - ucode_pkg::rt_mul_reg);
        end else begin
            rom_insn <= routine_word(rom_addr - ucode_pkg::rt_mul_imm);
        end
    end

endmodule

`default_nettype wire

// File: rtl/ucode_sequencer.sv
// micro engine; fetch and execute take one cycle each, so a run lasts roughly ten cycles per multiplier step.
`timescale 1ns/1ns
`default_nettype none
`include "ucode_macros.svh"

module ucode_sequencer (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic                              start,
    input  wire logic [$clog2(`UC_ROM_DEPTH)-1:0]  start_addr,
    input  wire logic [`UC_DATA_W-1:0]             op_a,
    input  wire logic [`UC_DATA_W-1:0]             op_b,
    input  wire logic [$clog2(`UC_NREGS)-1:0]      wb_reg,
    output logic      [$clog2(`UC_ROM_DEPTH)-1:0]  rom_addr,
    input  wire logic [`UC_INSN_W-1:0]             rom_insn,
    output logic                                   wb_en,
    output logic      [$clog2(`UC_NREGS)-1:0]      wb_addr,
    output logic      [`UC_DATA_W-1:0]             wb_data,
    output logic                                   seq_done
);

    localparam int aw = $clog2(`UC_ROM_DEPTH);
    localparam int dw = `UC_DATA_W;

    typedef enum logic [1:0] {st_idle, st_fetch, st_exec} state_t;

    state_t             state;
    ucode_pkg::uinsn_t  insn;
    logic [aw-1:0]      pc;
    logic [aw-1:0]      next_pc;
    logic [dw-1:0]      acc;
    logic [dw-1:0]      cnt;
    logic [dw-1:0]      mcand;
    logic [dw-1:0]      mplier;     // op_b held for the first mov.
    logic [dw-1:0]      dst_val;
    logic [dw-1:0]      src_val;
    logic [dw-1:0]      res;
    logic               zero;       // set by cmp.
    logic               wr;

    assign insn     = rom_insn;
    assign rom_addr = pc;
    assign wb_data  = acc;

    always_comb begin
        case (insn.dst)
            ucode_pkg::sc_acc: dst_val = acc;
            ucode_pkg::sc_cnt: dst_val = cnt;
            default:           dst_val = mcand;
        endcase
        if (insn.arg) begin
            src_val = mplier;
        end else if (insn.lit) begin
            src_val = dw'(insn.val);
        end else begin
            case (insn.src)
                ucode_pkg::sc_acc: src_val = acc;
                ucode_pkg::sc_cnt: src_val = cnt;
                default:           src_val = mcand;
            endcase
        end
        case (insn.op)
            ucode_pkg::uop_add: res = dst_val + src_val;
            ucode_pkg::uop_sub: res = dst_val - src_val;
            default:            res = src_val;          // mov.
        endcase
        wr = insn.op inside {ucode_pkg::uop_mov, ucode_pkg::uop_add, ucode_pkg::uop_sub};
        if (insn.op == ucode_pkg::uop_b || (insn.op == ucode_pkg::uop_bne && !zero)) begin
            next_pc = pc + aw'(insn.val);               // relative, wraps in the ROM.
        end else begin
            next_pc = pc + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            pc       <= '0;
            zero     <= 1'b0;
            wb_en    <= 1'b0;
            seq_done <= 1'b0;
        end else begin
            wb_en    <= 1'b0;
            seq_done <= 1'b0;
            case (state)
                st_idle: if (start) begin
                    state <= st_fetch;
                    pc    <= start_addr;
                end
                st_fetch: state <= st_exec;             // ROM read in flight.
                default: begin
                    state <= st_fetch;
                    pc    <= next_pc;
                    if (insn.op == ucode_pkg::uop_cmp) zero <= (dst_val == src_val);
                    if (insn.op == ucode_pkg::uop_halt) begin
                        state    <= st_idle;
                        wb_en    <= 1'b1;
                        seq_done <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            mcand   <= op_a;
            mplier  <= op_b;
            wb_addr <= wb_reg;
        end else if (state == st_exec && wr) begin
            case (insn.dst)
                ucode_pkg::sc_acc: acc   <= res;
                ucode_pkg::sc_cnt: cnt   <= res;
                default:           mcand <= res;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/reg_file_wb.sv
// register file; reads are registered and see no bypass, a writeback beats a load to the same register.
`timescale 1ns/1ns
`default_nettype none
`include "ucode_macros.svh"

module reg_file_wb (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          load,
    input  wire logic [$clog2(`UC_NREGS)-1:0]  load_reg,
    input  wire logic [`UC_DATA_W-1:0]         load_data,
    input  wire logic                          wb_en,
    input  wire logic [$clog2(`UC_NREGS)-1:0]  wb_reg,
    input  wire logic [`UC_DATA_W-1:0]         wb_data,
    input  wire logic [$clog2(`UC_NREGS)-1:0]  rd_addr_a,
    input  wire logic [$clog2(`UC_NREGS)-1:0]  rd_addr_b,
    output logic      [`UC_DATA_W-1:0]         rd_data_a,
    output logic      [`UC_DATA_W-1:0]         rd_data_b,
    output logic                               done,
    output logic      [$clog2(`UC_NREGS)-1:0]  result_reg,
    output logic      [`UC_DATA_W-1:0]         result_data
);

    logic [`UC_DATA_W-1:0] regs [`UC_NREGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `UC_NREGS; i++) begin
                regs[i] <= '0;                      // all registers read zero after reset.
            end
            done        <= 1'b0;
            result_reg  <= '0;
            result_data <= '0;
        end else begin
            if (load) regs[load_reg] <= load_data;
            if (wb_en) begin
                regs[wb_reg] <= wb_data;            // later assignment wins.
                result_reg   <= wb_reg;
                result_data  <= wb_data;
            end
            done <= wb_en;                          // echo of the write.
        end
    end

    // read ports, one cycle from address to data.
    always_ff @(posedge clk) begin
        rd_data_a <= regs[rd_addr_a];
        rd_data_b <= regs[rd_addr_b];
    end

endmodule

`default_nettype wire

// File: rtl/mul_ucode_top.sv
// microcoded multiply unit; one request at a time, the product is truncated to one data word.
`timescale 1ns/1ns
`default_nettype none
`include "ucode_macros.svh"

module mul_ucode_top (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          req,
    input  wire logic [6:0]                    opcode,
    input  wire logic [$clog2(`UC_NREGS)-1:0]  dest_reg,
    input  wire logic [$clog2(`UC_NREGS)-1:0]  reg1,
    input  wire logic [$clog2(`UC_NREGS)-1:0]  reg2,
    input  wire logic [`UC_DATA_W-1:0]         immediate,
    input  wire logic                          load,
    input  wire logic [$clog2(`UC_NREGS)-1:0]  load_reg,
    input  wire logic [`UC_DATA_W-1:0]         load_data,
    output logic                               busy,
    output logic                               illegal,
    output logic                               done,
    output logic      [$clog2(`UC_NREGS)-1:0]  result_reg,
    output logic      [`UC_DATA_W-1:0]         result_data
);

    logic [$clog2(`UC_NREGS)-1:0]     rd_addr_a;
    logic [$clog2(`UC_NREGS)-1:0]     rd_addr_b;
    logic [`UC_DATA_W-1:0]            rd_data_a;
    logic [`UC_DATA_W-1:0]            rd_data_b;
    logic                             start;
    logic [$clog2(`UC_ROM_DEPTH)-1:0] start_addr;
    logic [`UC_DATA_W-1:0]            op_a;
    logic [`UC_DATA_W-1:0]            op_b;
    logic [$clog2(`UC_NREGS)-1:0]     dec_wb_reg;   // destination from decode.
    logic [$clog2(`UC_ROM_DEPTH)-1:0] rom_addr;
    logic [`UC_INSN_W-1:0]            rom_insn;
    logic                             seq_done;
    logic                             wb_en;
    logic [$clog2(`UC_NREGS)-1:0]     wb_reg;       // destination held by the sequencer.
    logic [`UC_DATA_W-1:0]            wb_data;

    macro_decode macro_decode_i (
        .clk, .rst, .req, .opcode, .dest_reg, .reg1, .reg2, .immediate,
        .rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b, .seq_done,
        .busy, .illegal, .start, .start_addr, .op_a, .op_b, .wb_reg(dec_wb_reg)
    );

    ucode_rom ucode_rom_i (.clk, .rst, .rom_addr, .rom_insn);

    ucode_sequencer ucode_sequencer_i (
        .clk, .rst, .start, .start_addr, .op_a, .op_b, .wb_reg(dec_wb_reg),
        .rom_addr, .rom_insn, .wb_en, .wb_addr(wb_reg), .wb_data, .seq_done
    );

    reg_file_wb reg_file_wb_i (
        .clk, .rst, .load, .load_reg, .load_data, .wb_en, .wb_reg, .wb_data,
        .rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b,
        .done, .result_reg, .result_data
    );

endmodule

`default_nettype wire

// File: testbench/mul_ucode_props.sv
// strobe and busy assertions for the multiply unit; bound to the top level, quiet while rst is high.
`timescale 1ns/1ns
`default_nettype none

module mul_ucode_props (
    input wire logic       clk,
    input wire logic       rst,
    input wire logic       req,
    input wire logic [6:0] opcode,
    input wire logic       busy,
    input wire logic       illegal,
    input wire logic       done
);

    logic legal_op;     // one of the two mul forms.

    assign legal_op = (opcode == ucode_pkg::mul_imm) || (opcode == ucode_pkg::mul_reg);

    done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done stayed high for a second cycle");

    illegal_pulse: assert property (@(posedge clk) disable iff (rst) illegal |=> !illegal)
        else $error("illegal stayed high for a second cycle");

    // an accepted request with a bad opcode must leave busy low.
    no_busy_on_illegal: assert property (@(posedge clk) disable iff (rst)
        req && !busy && !legal_op |=> !busy)
        else $error("busy rose for an illegal opcode");

    busy_ends_at_done: assert property (@(posedge clk) disable iff (rst) done |-> !busy)
        else $error("busy still high while done is high");

endmodule

`default_nettype wire

// File: testbench/mul_ucode_checker.sv
// watches the DUT ports and predicts each product from a model file; assumes one multiply in flight.
`timescale 1ns/1ns
`default_nettype none
`include "ucode_macros.svh"

module mul_ucode_checker (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          req,
    input  wire logic [6:0]                    opcode,
    input  wire logic [$clog2(`UC_NREGS)-1:0]  dest_reg,
    input  wire logic [$clog2(`UC_NREGS)-1:0]  reg1,
    input  wire logic [$clog2(`UC_NREGS)-1:0]  reg2,
    input  wire logic [`UC_DATA_W-1:0]         immediate,
    input  wire logic                          load,
    input  wire logic [$clog2(`UC_NREGS)-1:0]  load_reg,
    input  wire logic [`UC_DATA_W-1:0]         load_data,
    input  wire logic                          busy,
    input  wire logic                          illegal,
    input  wire logic                          done,
    input  wire logic [$clog2(`UC_NREGS)-1:0]  result_reg,
    input  wire logic [`UC_DATA_W-1:0]         result_data,
    input  wire logic                          report,
    output int                                 error_count
);

    logic [`UC_DATA_W-1:0]         model [`UC_NREGS];  // expected file contents.
    logic [`UC_DATA_W-1:0]         exp_data;
    logic [`UC_DATA_W-1:0]         mplier;
    logic [$clog2(`UC_NREGS)-1:0]  exp_reg;
    logic                          pending;            // multiply accepted, done not yet seen.
    logic                          ill_due;            // illegal expected on this edge.
    logic                          exp_busy;
    logic                          done_q;
    logic                          after_rst;
    int                            errors = 0;
    int                            checks = 0;

    assign error_count = errors;

    task automatic flag_mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        errors++;
        $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("%0t: %s", $time, what);
    endtask

    // all DUT outputs are read before this edge updates them.
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `UC_NREGS; i++) begin
                model[i] = '0;
            end
            pending   = 1'b0;
            ill_due   = 1'b0;
            done_q    = 1'b0;
            after_rst = 1'b1;
        end else begin
            if (after_rst) begin
                checks++;
                if (result_reg !== '0) flag_mismatch("result_reg", 32'(result_reg), 32'd0);
                if (result_data !== '0) flag_mismatch("result_data", 32'(result_data), 32'd0);
                after_rst = 1'b0;
            end
            checks++;
            if (illegal !== ill_due) flag_mismatch("illegal", 32'(illegal), 32'(ill_due));
            ill_due  = 1'b0;
            exp_busy = pending && !done;        // high from acceptance until the done cycle.
            if (busy !== exp_busy) flag_mismatch("busy", 32'(busy), 32'(exp_busy));
            if (done && done_q) note_failure("done lasted more than one cycle");
            if (done) begin
                if (!pending) begin
                    note_failure("done without an accepted multiply");
                end else begin
                    checks++;
                    if (result_reg !== exp_reg) begin
                        flag_mismatch("result_reg", 32'(result_reg), 32'(exp_reg));
                    end
                    if (result_data !== exp_data) begin
                        flag_mismatch("result_data", 32'(result_data), 32'(exp_data));
                    end
                    model[exp_reg] = exp_data;      // file now holds the product.
                    pending        = 1'b0;
                end
            end
            if (req && !busy) begin
                if (opcode == ucode_pkg::mul_reg || opcode == ucode_pkg::mul_imm) begin
                    mplier   = (opcode == ucode_pkg::mul_imm) ? immediate : model[reg2];
                    exp_data = model[reg1] * mplier;   // low word of the product.
                    exp_reg  = dest_reg;
                    pending  = 1'b1;
                end else begin
                    ill_due = 1'b1;                    // pulse due one edge later.
                end
            end
            if (load) model[load_reg] = load_data;
            done_q = done;
            if (report) begin
                if (pending) note_failure("multiply still outstanding at end of run");
                $display("checks %0d, errors %0d", checks, errors);
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/mul_ucode_tb.sv
// testbench for the multiply unit; operands stay small so a multiply finishes in a few hundred cycles.
`timescale 1ns/1ns
`default_nettype none
`include "ucode_macros.svh"

module mul_ucode_tb;

    localparam int rw = $clog2(`UC_NREGS);
    localparam int dw = `UC_DATA_W;

    typedef enum logic [1:0] {row_load, row_mul, row_bad, row_overlap} row_kind_t;

    // one stimulus row; value is the load data or the immediate.
    typedef struct packed {
        row_kind_t     kind;
        logic [6:0]    opcode;
        logic [rw-1:0] rd;
        logic [rw-1:0] r1;
        logic [rw-1:0] r2;
        logic [dw-1:0] value;
    } row_t;

    logic          clk;
    logic          rst;
    logic          req;
    logic [6:0]    opcode;
    logic [rw-1:0] dest_reg;
    logic [rw-1:0] reg1;
    logic [rw-1:0] reg2;
    logic [dw-1:0] immediate;
    logic          load;
    logic [rw-1:0] load_reg;
    logic [dw-1:0] load_data;
    logic          busy;
    logic          illegal;
    logic          done;
    logic [rw-1:0] result_reg;
    logic [dw-1:0] result_data;
    logic          report;          // asks the checker for its closing line.
    int            error_count;
    logic          timed_out;
    row_t          rows[$];
    int            seed = 32'h11a8;
    int            idx;

    mul_ucode_top mul_ucode_top_i (.*);

    mul_ucode_checker mul_ucode_checker_i (.*);

    bind mul_ucode_top mul_ucode_props mul_ucode_props_i (
        .clk(clk), .rst(rst), .req(req), .opcode(opcode),
        .busy(busy), .illegal(illegal), .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int small_value(input int mask);
        return $random(seed) & mask;
    endfunction

    function automatic void add_row(input row_kind_t kind, input logic [6:0] opc,
                                    input int rd, input int r1, input int r2, input int value);
        row_t r;
        r.kind   = kind;
        r.opcode = opc;
        r.rd     = rw'(rd);
        r.r1     = rw'(r1);
        r.r2     = rw'(r2);
        r.value  = dw'(value);
        rows.push_back(r);
    endfunction

    function automatic void build_table();
        add_row(row_mul,  ucode_pkg::mul_imm, 1, 9, 0, 7);      // r9 still zero from reset.
        add_row(row_load, 7'h0, 2, 0, 0, small_value('h1f));
        add_row(row_load, 7'h0, 3, 0, 0, small_value('h0f) + 1);
        add_row(row_load, 7'h0, 5, 0, 0, 'h9abc);
        add_row(row_load, 7'h0, 4, 0, 0, 0);
        add_row(row_mul,  ucode_pkg::mul_reg, 6, 2, 3, 0);
        add_row(row_mul,  ucode_pkg::mul_reg, 7, 5, 3, 0);      // wraps past one word.
        add_row(row_mul,  ucode_pkg::mul_imm, 8, 5, 0, 0);
        add_row(row_mul,  ucode_pkg::mul_imm, 8, 5, 0, 1);
        add_row(row_mul,  ucode_pkg::mul_imm, 10, 2, 0, 13);
        add_row(row_mul,  ucode_pkg::mul_reg, 11, 5, 4, 0);     // zero multiplier in r4.
        add_row(row_bad,  ucode_pkg::muls_imm, 12, 2, 3, 3);
        add_row(row_bad,  ucode_pkg::muls_reg, 12, 2, 3, 0);
        add_row(row_bad,  7'h00, 12, 2, 3, 0);
        add_row(row_bad,  7'h7f, 12, 2, 3, 0);
        add_row(row_overlap, ucode_pkg::mul_reg, 12, 3, 2, 0);
        add_row(row_mul,  ucode_pkg::mul_reg, 14, 6, 3, 0);     // r6 came from a writeback.
        add_row(row_mul,  ucode_pkg::mul_imm, 15, 14, 0, 3);
        add_row(row_mul,  ucode_pkg::mul_reg, 2, 2, 3, 0);      // source is also the destination.
        for (int k = 0; k < 3; k++) begin
            add_row(row_load, 7'h0, 13, 0, 0, small_value('hff));
            add_row(row_mul,  ucode_pkg::mul_imm, 0, 13, 0, small_value('h1f));
        end
    endfunction

    // waits at falling edges for done, or for illegal, up to limit cycles.
    task automatic await_strobe(input logic want_illegal, input int limit);
        int n;
        n = 0;
        while (!(want_illegal ? illegal : done) && !timed_out) begin
            @(negedge clk);
            n++;
            if (n > limit) begin
                timed_out = 1'b1;
                $display("%0t: timeout, no %s after the request", $time,
                         want_illegal ? "illegal pulse" : "done");
            end
        end
    endtask

    task automatic issue_request(input row_t r);
        req       = 1'b1;
        opcode    = r.opcode;
        dest_reg  = r.rd;
        reg1      = r.r1;
        reg2      = r.r2;
        immediate = r.value;
        @(negedge clk);
        req = 1'b0;
    endtask

    task automatic apply_row(input row_t r);
        case (r.kind)
            row_load: begin
                load      = 1'b1;
                load_reg  = r.rd;
                load_data = r.value;
                @(negedge clk);
                load = 1'b0;
            end
            row_bad: begin
                issue_request(r);
                await_strobe(1'b1, 8);
                repeat (4) @(negedge clk);      // window for a stray busy or done.
            end
            row_overlap: begin
                issue_request(r);
                repeat (3) @(negedge clk);
                req      = 1'b1;                // dropped, the unit is busy.
                opcode   = ucode_pkg::mul_imm;
                dest_reg = r.rd + 1'b1;
                @(negedge clk);
                req = 1'b0;
                await_strobe(1'b0, 2000);
            end
            default: begin
                issue_request(r);
                await_strobe(1'b0, 2000);
            end
        endcase
    endtask

    initial begin
        rst       = 1'b1;
        req       = 1'b0;
        opcode    = '0;
        dest_reg  = '0;
        reg1      = '0;
        reg2      = '0;
        immediate = '0;
        load      = 1'b0;
        load_reg  = '0;
        load_data = '0;
        report    = 1'b0;
        timed_out = 1'b0;
        build_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        idx = 0;
        while (idx < rows.size() && !timed_out) begin
            apply_row(rows[idx]);
            idx++;
        end
        repeat (6) @(negedge clk);              // catch a late done.
        report = 1'b1;
        @(negedge clk);
        report = 1'b0;
        @(negedge clk);
        if (timed_out || error_count != 0) begin
            $display("Verification failed");
        end else begin
            $display("Verification passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+rtl
rtl/ucode_pkg.sv
rtl/macro_decode.sv
rtl/ucode_rom.sv
rtl/ucode_sequencer.sv
rtl/reg_file_wb.sv
rtl/mul_ucode_top.sv
testbench/mul_ucode_props.sv
testbench/mul_ucode_checker.sv
testbench/mul_ucode_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: all build lint clean

all: build
	./obj_dir/Vmul_ucode_tb +verilator+error+limit+100 | tee $(LOG)
	grep -q "Verification passed" $(LOG)

build:
	verilator --binary --timing --assert -Wno-fatal --top-module mul_ucode_tb -f compile.f

lint:
	verilator --lint-only -Wall --timing --assert --top-module mul_ucode_tb -f compile.f

clean:
	rm -rf obj_dir $(LOG)
